/* adc_cfg_seq.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module adc_cfg_seq import ltc2195_pkg::*; (
	input  logic      hz_clk,
	input  logic      rst_in,
	input  logic      cmd_trig,   // Host request, honoured only with cmd_ready
	input  cmd_addr_t cmd_addr,
	input  reg_data_t cmd_data,
	input  logic      spi_busy,
	output logic      cmd_ready,
	output logic      spi_start,
	output spi_word_t spi_word
);

	localparam int WAIT_W = $clog2(`INIT_WAIT + 1);

	cfg_state_t        state;
	logic [WAIT_W-1:0] wait_cnt;   // Power-up delay
	logic [1:0]        wr_idx;     // Power-up write, 3 once all are sent
	reg_addr_t         init_addr;
	reg_data_t         init_data;
	logic              cmd_accept;

	//////////////////////////////////////////////////
	// Power-up register table

	always_comb begin
		init_addr = reg_addr_t'(wr_idx); // Registers 0, 1, 2 in order
		case (wr_idx)
			2'd0:    init_data = `REG_RESET_VAL;
			2'd1:    init_data = `REG_FORMAT_VAL;
			default: init_data = `REG_LANES_VAL;
		endcase
	end

	assign cmd_ready  = (state == CFG_IDLE);
	assign spi_start  = (state == CFG_START); // START lasts one cycle
	assign cmd_accept = cmd_ready && cmd_trig && (cmd_addr[15:8] == `WRITE_PAGE);

	//////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			state    <= CFG_WAIT;
			wait_cnt <= WAIT_W'(`INIT_WAIT);
			wr_idx   <= 2'd0;
		end
		else begin
			case (state)
				CFG_WAIT: begin
					if (wait_cnt == '0)
						state <= CFG_LOAD;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				CFG_LOAD:  state <= CFG_START;
				CFG_START: state <= CFG_BUSY; // Master raises busy on this edge
				CFG_BUSY: begin
					if (!spi_busy) begin
						if (wr_idx == 2'd3) begin
							state <= CFG_IDLE;    // Host write finished
						end
						else begin
							wr_idx <= wr_idx + 1'b1;
							state  <= (wr_idx == 2'd2) ? CFG_IDLE : CFG_LOAD;
						end
					end
				end
				CFG_IDLE: begin
					if (cmd_accept)
						state <= CFG_START;     // Other pages fall through
				end
				default: state <= CFG_IDLE;
			endcase
		end
	end

	// Frame word, held for the master to sample on spi_start
	always_ff @(posedge hz_clk) begin
		if (state == CFG_LOAD)
			spi_word <= {1'b0, init_addr, init_data};
		else if (cmd_accept)
			spi_word <= {1'b0, cmd_addr[6:0], cmd_data}; // Write bit is 0
	end

endmodule

/* frame_align.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module frame_align import ltc2195_pkg::*; (
	input  logic       hz_clk,
	input  logic       rst_in,
	input  lane_word_t frame_word,   // Captured frame lane
	input  logic       word_strobe,
	output logic       slip,         // One-cycle bitslip request
	output logic       frame_locked  // Last compared word was the pattern
);

	localparam int SET_W = $clog2(`SLIP_SETTLE + 1);

	align_state_t     state;
	logic [SET_W-1:0] settle_cnt; // Words seen since the last slip, saturating
	logic             match;
	logic             settled;

	assign match   = (frame_word == `TRAIN_PATTERN);
	assign settled = (settle_cnt == SET_W'(`SLIP_SETTLE));
	assign slip    = (state == ALIGN_SLIP); // Cycle after a strobe

	//////////////////////////////////////////////////
	// Bitslip FSM

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			state        <= ALIGN_CHECK;
			settle_cnt   <= '0;
			frame_locked <= 1'b0;
		end
		else begin
			case (state)
				ALIGN_CHECK: begin
					if (word_strobe) begin
						frame_locked <= match;
						if (!match && settled)
							state <= ALIGN_SLIP;               // Shift boundary once
						else if (!settled)
							settle_cnt <= settle_cnt + 1'b1;   // Let old words drain
					end
				end
				ALIGN_SLIP: begin
					state      <= ALIGN_CHECK;
					settle_cnt <= '0;
				end
				default: state <= ALIGN_CHECK;
			endcase
		end
	end

	// A slip needs two strobes before its effect reaches frame_word,
	// the settle count keeps us from slipping past the right boundary

endmodule

/* lane_deser.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module lane_deser import ltc2195_pkg::*; (
	input  logic       hz_clk,
	input  logic       rst_in,
	input  logic       serial_bit,  // One bit per clock
	input  logic       word_strobe, // From word_timer, shared by all lanes
	output lane_word_t lane_word
);

	lane_word_t shift_reg;

	//////////////////////////////////////////////////
	// Shifter

	// MSB first, first bit of a word ends up at the top
	always_ff @(posedge hz_clk) begin
		shift_reg <= {shift_reg[`LANE_BITS-2:0], serial_bit};
	end

	// Capture holds a full word until the next strobe
	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			lane_word <= '0;
		end
		else if (word_strobe) begin
			lane_word <= shift_reg; // Eighth bit shifted in on the previous clock
		end
	end

	// Shifter keeps running through reset so the first word is full

endmodule

/* ltc2195_macros.svh */
`ifndef LTC2195_MACROS_SVH
`define LTC2195_MACROS_SVH

// Serial receive path
`define LANE_BITS      8           // Bits per lane word
`define SAMPLE_BITS    16          // Two lanes interleaved
`define TRAIN_PATTERN  8'b00001111 // Frame lane idle word
`define SLIP_SETTLE    3           // Words between two slips

// SPI configuration
`define SPI_BITS       16          // R/W bit, 7 addr, 8 data
`define INIT_WAIT      255         // Clocks before the first write
`define SCK_HALF       5           // hz_clk cycles per SCK half period
`define WRITE_PAGE     8'h31       // Host page that maps to a write

// Power-up register values
`define REG_RESET_VAL  8'h80       // Soft reset
`define REG_FORMAT_VAL 8'h20       // Two's complement output
`define REG_LANES_VAL  8'h00       // Two-lane mode, 16-bit serialization

`endif

/* ltc2195_pkg.sv */
`include "ltc2195_macros.svh"

package ltc2195_pkg;

	// Data path words
	typedef logic [`LANE_BITS-1:0] lane_word_t;          // One deserialized lane
	typedef logic signed [`SAMPLE_BITS-1:0] sample_t;    // Reassembled ADC sample

	// SPI and host command fields
	typedef logic [`SPI_BITS-1:0] spi_word_t;            // {wr, addr[6:0], data[7:0]}
	typedef logic [6:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [15:0] cmd_addr_t;                     // Page in upper byte

	// Configuration sequencer
	typedef enum logic [2:0] {
		CFG_WAIT,  // Power-up delay
		CFG_LOAD,  // Build next power-up word
		CFG_START, // Kick the SPI master
		CFG_BUSY,  // Frame on the wire
		CFG_IDLE   // Ready for host commands
	} cfg_state_t;

	// Frame aligner
	typedef enum logic {
		ALIGN_CHECK,
		ALIGN_SLIP
	} align_state_t;

endpackage

/* ltc2195_rx_chk.sv */
`timescale 1ns/1ns

module ltc2195_rx_chk (
	input logic hz_clk,
	input logic rst_in,
	input logic spi_scs,
	input logic spi_sck,
	input logic cmd_ready,
	input logic sample_valid,
	input logic frame_locked
);

	//////////////////////////////////////////////////
	// SPI framing

	// SCK only toggles inside a selected frame
	sck_idle_low: assert property (@(posedge hz_clk) disable iff (rst_in)
		spi_scs |-> !spi_sck)
		else $error("spi_sck is high while spi_scs is high");

	// No host command while a frame is on the wire
	ready_off_in_frame: assert property (@(posedge hz_clk) disable iff (rst_in)
		!spi_scs |-> !cmd_ready)
		else $error("cmd_ready is high while spi_scs is low");

	//////////////////////////////////////////////////
	// Receive path

	valid_single: assert property (@(posedge hz_clk) disable iff (rst_in)
		sample_valid |=> !sample_valid) // One pulse per word
		else $error("sample_valid stayed high for two cycles");

	locked_in_reset: assert property (@(posedge hz_clk) rst_in |-> !frame_locked)
		else $error("frame_locked is high during reset");

endmodule

bind ltc2195_rx_top ltc2195_rx_chk ltc2195_rx_chk_inst (
	.hz_clk(hz_clk),
	.rst_in(rst_in),
	.spi_scs(spi_scs),
	.spi_sck(spi_sck),
	.cmd_ready(cmd_ready),
	.sample_valid(sample_valid),
	.frame_locked(frame_locked)
);

/* ltc2195_rx_top.sv */
`timescale 1ns/1ns

module ltc2195_rx_top import ltc2195_pkg::*; (
	input  logic      hz_clk,
	input  logic      rst_in,
	// Host command
	input  logic      cmd_trig,
	input  cmd_addr_t cmd_addr,
	input  reg_data_t cmd_data,
	output logic      cmd_ready,
	// SPI to the ADC
	output logic      spi_scs,
	output logic      spi_sck,
	output logic      spi_sdo,
	// Serial lanes
	input  logic      d0a,
	input  logic      d0b,
	input  logic      d1a,
	input  logic      d1b,
	input  logic      frame_bit,
	// Samples
	output sample_t   sample0,
	output sample_t   sample1,
	output logic      sample_valid,
	output logic      frame_locked
);

	logic       spi_start;
	logic       spi_busy;
	spi_word_t  spi_word;
	logic       word_strobe;
	logic       slip;
	lane_word_t d0a_word, d0b_word, d1a_word, d1b_word, frame_word;

	//////////////////////////////////////////////////
	// Configuration path

	adc_cfg_seq adc_cfg_seq_inst (.hz_clk, .rst_in, .cmd_trig, .cmd_addr, .cmd_data,
		.spi_busy, .cmd_ready, .spi_start, .spi_word);

	spi_master spi_master_inst (.hz_clk, .rst_in, .spi_start, .spi_word,
		.spi_busy, .spi_scs, .spi_sck, .spi_sdo);

	//////////////////////////////////////////////////
	// Receive path

	word_timer word_timer_inst (.hz_clk, .rst_in, .slip, .word_strobe); // Shared boundary

	lane_deser d0a_deser (.hz_clk, .rst_in, .serial_bit(d0a), .word_strobe, .lane_word(d0a_word));
	lane_deser d0b_deser (.hz_clk, .rst_in, .serial_bit(d0b), .word_strobe, .lane_word(d0b_word));
	lane_deser d1a_deser (.hz_clk, .rst_in, .serial_bit(d1a), .word_strobe, .lane_word(d1a_word));
	lane_deser d1b_deser (.hz_clk, .rst_in, .serial_bit(d1b), .word_strobe, .lane_word(d1b_word));
	lane_deser fr_deser (.hz_clk, .rst_in, .serial_bit(frame_bit), .word_strobe,
		.lane_word(frame_word));

	frame_align frame_align_inst (.hz_clk, .rst_in, .frame_word, .word_strobe,
		.slip, .frame_locked);

	// Channel 1 strobes in step with channel 0
	sample_assemble ch0_assemble (.hz_clk, .rst_in, .lane_a(d0a_word), .lane_b(d0b_word),
		.word_strobe, .sample(sample0), .sample_valid(sample_valid));
	sample_assemble ch1_assemble (.hz_clk, .rst_in, .lane_a(d1a_word), .lane_b(d1b_word),
		.word_strobe, .sample(sample1), .sample_valid());

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_ltc2195_rx \
	-f sources.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* sample_assemble.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module sample_assemble import ltc2195_pkg::*; (
	input  logic       hz_clk,
	input  logic       rst_in,
	input  lane_word_t lane_a,       // Odd sample bits
	input  lane_word_t lane_b,       // Even sample bits
	input  logic       word_strobe,
	output sample_t    sample,
	output logic       sample_valid  // One cycle per new sample
);

	logic    strobe_d; // Lane words settle one cycle after the strobe
	sample_t mixed;

	//////////////////////////////////////////////////
	// Interleave

	always_comb begin
		for (int k = 0; k < `LANE_BITS; k++) begin
			mixed[2*k+1] = lane_a[k];
			mixed[2*k]   = lane_b[k];
		end
	end

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			strobe_d     <= 1'b0;
			sample_valid <= 1'b0;
		end
		else begin
			strobe_d     <= word_strobe;
			sample_valid <= strobe_d;    // Strobe + 2
		end
	end

	always_ff @(posedge hz_clk) begin
		if (strobe_d)
			sample <= mixed;
	end

endmodule

/* sources.f */
+incdir+.
ltc2195_pkg.sv
spi_master.sv
adc_cfg_seq.sv
word_timer.sv
lane_deser.sv
frame_align.sv
sample_assemble.sv
ltc2195_rx_top.sv
ltc2195_rx_chk.sv
tb_ltc2195_rx.sv

/* spi_master.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module spi_master import ltc2195_pkg::*; (
	input  logic      hz_clk,
	input  logic      rst_in,
	input  logic      spi_start, // One-cycle request
	input  spi_word_t spi_word,  // Sampled on spi_start
	output logic      spi_busy,
	output logic      spi_scs,
	output logic      spi_sck,
	output logic      spi_sdo
);

	// One setup half plus 32 toggling halves plus one trail half
	localparam int HALVES = 2 * `SPI_BITS + 2;
	localparam int HC_W = $clog2(`SCK_HALF + 1);

	logic [HC_W-1:0] half_cnt;   // Cycles inside one half period
	logic [5:0]      half_idx;   // Which half period of the frame
	spi_word_t       shift_reg;

	assign spi_sdo = shift_reg[`SPI_BITS-1]; // MSB first

	//////////////////////////////////////////////////
	// Frame timing

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			spi_busy  <= 1'b0;
			spi_scs   <= 1'b1;
			spi_sck   <= 1'b0;
			half_cnt  <= '0;
			half_idx  <= '0;
			shift_reg <= '0;
		end
		else if (!spi_busy) begin
			if (spi_start) begin
				spi_busy  <= 1'b1;
				half_cnt  <= '0;
				half_idx  <= '0;
				shift_reg <= spi_word; // Frame latched here so the sequencer may move on
			end
		end
		else if (half_cnt == HC_W'(`SCK_HALF - 1)) begin
			half_cnt <= '0;
			half_idx <= half_idx + 1'b1;
			if (half_idx == '0) begin
				spi_scs <= 1'b0;          // Select the chip after the setup half
			end
			else if (half_idx == 6'(HALVES - 1)) begin
				spi_scs  <= 1'b1;         // Trail half done
				spi_busy <= 1'b0;
			end
			else begin
				spi_sck <= ~spi_sck;
				// Falling edge moves the next bit onto SDO
				if (spi_sck) begin
					shift_reg <= {shift_reg[`SPI_BITS-2:0], 1'b0};
				end
			end
		end
		else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Halves 1..32 toggle SCK at their end
	// Half 1 is the lead with SDO already valid
	// Half 33 is the trail after the last falling edge
	// SCK therefore ends low and makes exactly 16 rising edges

endmodule

/* tb_ltc2195_rx.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module tb_ltc2195_rx;

	localparam int MAX_CYCLES = 20000;         // Power-up ~900, commands ~700, two aligns ~1000
	localparam logic [31:0] SEED = 32'h8fcaef77;

	logic               hz_clk = 1'b0;
	logic               rst_in;
	logic               cmd_trig;
	logic [15:0]        cmd_addr;
	logic [7:0]         cmd_data;
	logic               cmd_ready;
	logic               spi_scs;
	logic               spi_sck;
	logic               spi_sdo;
	logic               d0a = 1'b0;
	logic               d0b = 1'b0;
	logic               d1a = 1'b0;
	logic               d1b = 1'b0;
	logic               frame_bit = 1'b0;
	logic signed [15:0] sample0;
	logic signed [15:0] sample1;
	logic               sample_valid;
	logic               frame_locked;

	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          cyc_cnt = 0;
	logic [31:0] rnd_state = SEED;

	// SPI capture model state
	logic [15:0] spi_q[$];     // Completed frames, oldest first
	logic [15:0] cap_shift = '0;
	int          cap_bits = 0;
	int          scs_falls = 0;
	logic        sck_prev = 1'b0;
	logic        scs_prev = 1'b1;

	// Lane driver state
	logic [2:0]  lane_pos = '0;
	logic [2:0]  lane_offset = '0; // Misplaces the word boundary
	logic [7:0]  fr_word = '0;     // Idle frame lane until alignment test
	logic [7:0]  d0a_word = '0;
	logic [7:0]  d0b_word = '0;
	logic [7:0]  d1a_word = '0;
	logic [7:0]  d1b_word = '0;
	logic [15:0] s0_exp;
	logic [15:0] s1_exp;

	ltc2195_rx_top ltc2195_rx_top_inst (.hz_clk, .rst_in, .cmd_trig, .cmd_addr, .cmd_data,
		.cmd_ready, .spi_scs, .spi_sck, .spi_sdo, .d0a, .d0b, .d1a, .d1b, .frame_bit,
		.sample0, .sample1, .sample_valid, .frame_locked);

	always #4 hz_clk = ~hz_clk; // 8 ns period

	//////////////////////////////////////////////////
	// Watchdog, capture model and lane driver

	always @(posedge hz_clk) begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles with %0d errors", cyc_cnt, err_cnt);
			$display("Test failed");
			$finish;
		end
	end

	// SPI outputs move on posedge, so look at them on negedge
	always @(negedge hz_clk) begin
		if (!spi_scs && scs_prev)
			scs_falls++;
		if (spi_scs) begin
			cap_bits = 0;                              // Frame boundary
		end
		else if (spi_sck && !sck_prev) begin
			cap_shift = {cap_shift[14:0], spi_sdo}; // MSB arrives first
			cap_bits++;
			if (cap_bits == `SPI_BITS) begin
				spi_q.push_back(cap_shift);
				cap_bits = 0;
			end
		end
		sck_prev = spi_sck;
		scs_prev = spi_scs;
	end

	// Word bit for a stream position, position 0 is the MSB
	function automatic logic bit_at(input logic [7:0] w, input logic [2:0] pos);
		return w[3'd7 - pos];
	endfunction

	always @(negedge hz_clk) begin
		frame_bit <= bit_at(fr_word, lane_pos + lane_offset);
		d0a       <= bit_at(d0a_word, lane_pos + lane_offset);
		d0b       <= bit_at(d0b_word, lane_pos + lane_offset);
		d1a       <= bit_at(d1a_word, lane_pos + lane_offset);
		d1b       <= bit_at(d1b_word, lane_pos + lane_offset);
		lane_pos  <= lane_pos + 3'd1;
	end

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Sample bit 2k+1 rides lane A, bit 2k rides lane B
	function automatic logic [7:0] odd_bits(input logic [15:0] s);
		logic [7:0] r;
		for (int k = 0; k < 8; k++)
			r[k] = s[2*k+1];
		return r;
	endfunction

	function automatic logic [7:0] even_bits(input logic [15:0] s);
		logic [7:0] r;
		for (int k = 0; k < 8; k++)
			r[k] = s[2*k];
		return r;
	endfunction

	task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic wait_lock(input logic level, input int limit);
		int n;
		n = 0;
		while (frame_locked !== level && n < limit) begin
			@(negedge hz_clk);
			n++;
		end
		chk_cnt++;
		assert (frame_locked === level) else begin
			$display("frame_locked did not go to %0d within %0d cycles", level, limit);
			err_cnt++;
		end
	endtask

	// Returns on the negedge that sees the next sample_valid pulse
	task automatic wait_valid();
		int n;
		n = 0;
		do begin
			@(negedge hz_clk);
			n++;
		end while (!sample_valid && n < 40);
		chk_cnt++;
		assert (sample_valid) else begin
			$display("No sample_valid pulse within 40 cycles");
			err_cnt++;
		end
	endtask

	task automatic send_cmd(input logic [15:0] addr, input logic [7:0] data);
		@(negedge hz_clk);
		cmd_trig = 1'b1;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge hz_clk);
		cmd_trig = 1'b0; // One-cycle pulse
	endtask

	// New random pair, spread over the four data lanes
	task automatic load_samples();
		rnd_state = xorshift32(rnd_state);
		s0_exp = rnd_state[15:0];
		s1_exp = rnd_state[31:16];
		d0a_word <= odd_bits(s0_exp);
		d0b_word <= even_bits(s0_exp);
		d1a_word <= odd_bits(s1_exp);
		d1b_word <= even_bits(s1_exp);
	endtask

	//////////////////////////////////////////////////
	// Tests

	task automatic test_power_up();
		int n;
		n = 0;
		while (!(spi_q.size() >= 3 && spi_scs) && n < 2000) begin
			@(negedge hz_clk);
			n++;
			check_bit("cmd_ready", cmd_ready, 1'b0); // Held off through all three frames
		end
		repeat (10) @(negedge hz_clk);
		check_bit("cmd_ready", cmd_ready, 1'b1);
		repeat (20) @(negedge hz_clk);
		chk_cnt++;
		assert (spi_q.size() == 3) else begin
			$display("Expected 3 power-up SPI frames, saw %0d", spi_q.size());
			err_cnt++;
		end
		if (spi_q.size() == 3) begin
			check_word("spi_word", spi_q.pop_front(), 16'h0080); // Soft reset
			check_word("spi_word", spi_q.pop_front(), 16'h0120); // Two's complement
			check_word("spi_word", spi_q.pop_front(), 16'h0200); // Two lanes
		end
		spi_q.delete();
	endtask

	task automatic test_host_write();
		int n;
		send_cmd(16'h3105, 8'hA7);
		check_bit("cmd_ready", cmd_ready, 1'b0); // Falls the cycle after the trigger
		n = 0;
		while (!(spi_q.size() >= 1 && cmd_ready) && n < 400) begin
			@(negedge hz_clk);
			n++;
		end
		check_bit("cmd_ready", cmd_ready, 1'b1);
		chk_cnt++;
		assert (spi_q.size() == 1) else begin
			$display("Host write gave %0d SPI frames instead of one", spi_q.size());
			err_cnt++;
		end
		if (spi_q.size() == 1)
			check_word("spi_word", spi_q.pop_front(), 16'h05A7);
		spi_q.delete();
	endtask

	task automatic test_ignored_cmd();
		int falls0;
		falls0 = scs_falls;
		send_cmd(16'h3005, 8'h5A); // Wrong page
		repeat (500) begin
			@(negedge hz_clk);
			check_bit("cmd_ready", cmd_ready, 1'b1);
		end
		chk_cnt++;
		assert (scs_falls == falls0) else begin
			$display("A command on a foreign page started an SPI frame");
			err_cnt++;
		end
	endtask

	task automatic test_align();
		@(negedge hz_clk);
		load_samples();
		rnd_state = xorshift32(rnd_state);
		lane_offset <= rnd_state[2:0];   // 0 to 7 bits off
		fr_word     <= `TRAIN_PATTERN;
		wait_lock(1'b1, 400);
		wait_valid();
		wait_valid();
		check_word("sample0", sample0, s0_exp);
		check_word("sample1", sample1, s1_exp);
	endtask

	task automatic test_realign();
		@(negedge hz_clk);
		lane_offset <= lane_offset + 3'd1; // Boundary off by one bit
		load_samples();
		wait_lock(1'b0, 40);
		wait_lock(1'b1, 400);
		wait_valid();
		wait_valid();
		check_word("sample0", sample0, s0_exp);
		check_word("sample1", sample1, s1_exp);
	endtask

	initial begin
		rst_in   = 1'b1;
		cmd_trig = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		repeat (4) @(negedge hz_clk);
		rst_in = 1'b0;
		test_power_up();
		test_host_write();
		test_ignored_cmd();
		test_align();
		test_realign();
		$display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* word_timer.sv */
`timescale 1ns/1ns
`include "ltc2195_macros.svh"

module word_timer (
	input  logic hz_clk,
	input  logic rst_in,
	input  logic slip,        // Stretch current word by one bit
	output logic word_strobe  // Last bit of a word is in the shifters
);

	localparam int CNT_W = $clog2(`LANE_BITS);

	logic [CNT_W-1:0] bit_cnt;

	// Strobe on the final count of each word
	assign word_strobe = (bit_cnt == CNT_W'(`LANE_BITS - 1));

	//////////////////////////////////////////////////
	// Bit counter

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			bit_cnt <= '0;
		end
		else if (!slip) begin
			if (word_strobe)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
		// On slip the count holds, boundary moves one bit later
	end

	// Slip arrives right after a strobe, so the held count is never the wrap
	// and two strobes stay at least LANE_BITS apart

endmodule
